/* fetch.f */
verilog/fetchPkg.sv
verilog/progCounter.sv
verilog/instrMem.sv
verilog/control.sv
verilog/hazardDetect.sv
verilog/fetch.sv
tb/fetchTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module fetchTb -f fetch.f -o fetchSim \
    && ./obj_dir/fetchSim | tee /dev/stderr | grep -qx "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb/fetchTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

    import fetchPkg::*;

    localparam int MAX_ENTRIES = 64;
    localparam int ACK_LIMIT   = 8;  // Cycles allowed per handshake phase

    logic    clk;
    logic    arstN;
    logic    run;
    logic    pcSel;
    addrT    brnchAddr;
    dataT    rs;
    dataT    imm;
    logic    loadReq;
    addrT    loadAddr;
    instrT   loadData;
    logic    loadAck;
    addrT    pc;
    instrT   instrC;
    regAddrT writeRegAddr;
    logic    regWrite;
    logic    memEnable;
    logic    memWr;
    logic    val2Reg;
    logic    aluSel;
    immSelT  immSel;
    logic    bFlag;
    logic    jFlag;
    logic    regJmp;
    logic    halt;
    logic    ctrlErr;

    // Tables filled from the data file
    addrT        progAddr   [MAX_ENTRIES];
    instrT       progWord   [MAX_ENTRIES];
    string       traceName  [MAX_ENTRIES];
    logic [15:0] tracePcSel [MAX_ENTRIES];
    addrT        traceBrnch [MAX_ENTRIES];
    dataT        traceRs    [MAX_ENTRIES];
    dataT        traceImm   [MAX_ENTRIES];
    addrT        expPc      [MAX_ENTRIES];
    instrT       expInstr   [MAX_ENTRIES];
    logic [15:0] expWra     [MAX_ENTRIES];
    logic [15:0] expCtrl    [MAX_ENTRIES];

    int   progCount;
    int   traceCount;
    int   checkCount;
    int   errorCount;
    int   watchCycles;
    logic loadFailed;

    fetch #(
        .MEM_WORDS (256)
    ) fetch_i (
        .clk          (clk),
        .arstN        (arstN),
        .run          (run),
        .pcSel        (pcSel),
        .brnchAddr    (brnchAddr),
        .rs           (rs),
        .imm          (imm),
        .loadReq      (loadReq),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .loadAck      (loadAck),
        .pc           (pc),
        .instrC       (instrC),
        .writeRegAddr (writeRegAddr),
        .regWrite     (regWrite),
        .memEnable    (memEnable),
        .memWr        (memWr),
        .val2Reg      (val2Reg),
        .aluSel       (aluSel),
        .immSel       (immSel),
        .bFlag        (bFlag),
        .jFlag        (jFlag),
        .regJmp       (regJmp),
        .halt         (halt),
        .ctrlErr      (ctrlErr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Same bit order as the ctrl column of the data file
    function automatic logic [15:0] ctrlBits();
        return {3'b000, regWrite, memEnable, memWr, val2Reg, aluSel, immSel,
                bFlag, jFlag, regJmp, halt, ctrlErr};
    endfunction

    task automatic checkValue(input string testName, input string field,
                              input logic [15:0] expected, input logic [15:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("FAIL %s %s: expected %h, actual %h", testName, field, expected, actual);
        end
    endtask

    task automatic readTests();
        int          fd;
        int          code;
        string       tag;
        string       rest;
        string       name;
        logic [15:0] f [8];
        fd = $fopen("tb/fetch_tests.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open tb/fetch_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    // Trailing blank space at end of file
                end else if (tag[0] == 8'h23) begin
                    code = $fgets(rest, fd);  // Comment line
                end else if (tag == "P" && progCount < MAX_ENTRIES) begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    progAddr[progCount] = f[0];
                    progWord[progCount] = f[1];
                    progCount++;
                end else if (tag == "T" && traceCount < MAX_ENTRIES) begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", name,
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    traceName[traceCount]  = name;
                    tracePcSel[traceCount] = f[0];
                    traceBrnch[traceCount] = f[1];
                    traceRs[traceCount]    = f[2];
                    traceImm[traceCount]   = f[3];
                    expPc[traceCount]      = f[4];
                    expInstr[traceCount]   = f[5];
                    expWra[traceCount]     = f[6];
                    expCtrl[traceCount]    = f[7];
                    traceCount++;
                end else begin
                    errorCount++;
                    $display("Unexpected entry %s in tests file", tag);
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // Writes one program word by four-phase handshake from falling edge to falling edge
    task automatic loadWord(input addrT wordAddr, input instrT word);
        int waited;
        checkValue("load", "loadAck before req", 16'h0000, {15'b0, loadAck});
        loadAddr = wordAddr;
        loadData = word;
        loadReq  = 1'b1;
        waited   = 0;
        @(negedge clk);
        while (!loadAck && waited < ACK_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!loadAck) begin
            errorCount++;
            loadFailed = 1'b1;
            $display("Timeout: loadAck never rose for the word at address %h", wordAddr);
        end else begin
            // Ack has to stay up as long as the request does
            @(negedge clk);
            checkValue("load", "loadAck held", 16'h0001, {15'b0, loadAck});
            loadReq = 1'b0;
            waited  = 0;
            @(negedge clk);
            while (loadAck && waited < ACK_LIMIT) begin
                waited++;
                @(negedge clk);
            end
            if (loadAck) begin
                errorCount++;
                loadFailed = 1'b1;
                $display("Timeout: loadAck stuck high after loadReq fell at address %h",
                         wordAddr);
            end
        end
    endtask

    // One trace line is one clock cycle
    task automatic runLine(input int idx);
        string name;
        name      = traceName[idx];
        run       = 1'b1;
        pcSel     = tracePcSel[idx][0];
        brnchAddr = traceBrnch[idx];
        rs        = traceRs[idx];
        imm       = traceImm[idx];
        #1;  // Mid-cycle sample well clear of the rising edge
        checkValue(name, "pc", expPc[idx], pc);
        checkValue(name, "instrC", expInstr[idx], instrC);
        checkValue(name, "writeRegAddr", expWra[idx], {13'b0, writeRegAddr});
        checkValue(name, "ctrl", expCtrl[idx], ctrlBits());
        @(negedge clk);
    endtask

    initial begin
        arstN       = 1'b0;
        run         = 1'b0;
        pcSel       = 1'b0;
        brnchAddr   = '0;
        rs          = '0;
        imm         = '0;
        loadReq     = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        progCount   = 0;
        traceCount  = 0;
        checkCount  = 0;
        errorCount  = 0;
        loadFailed  = 1'b0;
        watchCycles = 0;
        readTests();
        if (progCount == 0 || traceCount == 0) begin
            errorCount++;
            $display("Tests file holds no program words or no trace lines");
        end
        watchCycles = progCount * 4 + traceCount + 20;
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        #1;
        checkValue("reset", "pc", 16'h0000, pc);
        checkValue("reset", "instrC", NOP_INSTR, instrC);
        checkValue("reset", "ctrl", 16'h0000, ctrlBits());
        @(negedge clk);
        for (int i = 0; i < progCount && !loadFailed; i++) begin
            loadWord(progAddr[i], progWord[i]);
        end
        if (!loadFailed) begin
            for (int i = 0; i < traceCount; i++) begin
                runLine(i);
            end
        end
        run   = 1'b0;
        pcSel = 1'b0;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchCycles != 0);
        repeat (watchCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the run finished", watchCycles);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/fetch_tests.txt */
# P <byte address> <word>   all values hex
# T <test> <pcSel> <brnchAddr> <rs> <imm> <exp pc> <exp instrC> <exp writeRegAddr> <exp ctrl>
# ctrl bits 12..0 are regWrite memEnable memWr val2Reg aluSel immSel[2:0] bFlag jFlag regJmp halt ctrlErr
P 0000 C105
P 0002 4143
P 0004 8960
P 0006 DB30
P 0008 8282
P 000A 6104
P 0010 2A04
P 0018 3002
P 0020 F800
P 0022 88A0
P 0024 81A0
P 0026 0000
T lbi       0 0000 0000 0000 0000 C105 1 1140
T addi      0 0000 0000 0000 0002 4143 2 1120
T ld        0 0000 0000 0000 0004 8960 3 1B20
T ldBubble  0 0000 0000 0000 0006 0800 0 0000
T aluDep    0 0000 0000 0000 0006 DB30 4 1000
T st        0 0000 0000 0000 0008 8282 2 0D20
T beqz      1 0010 0000 0000 000A 6104 1 0050
T jr        0 0000 0010 0008 0010 2A04 2 004C
T jal       1 0020 0000 0000 0018 3002 7 1068
T illegal   0 0000 0000 0000 0020 F800 0 0001
T ld2       0 0000 0000 0000 0022 88A0 5 1B20
T stBubble  0 0000 0000 0000 0024 0800 0 0000
T stDep     0 0000 0000 0000 0024 81A0 1 0D20
T halt      0 0000 0000 0000 0026 0000 0 0002
T haltHold  1 0040 0000 0000 0026 0000 0 0002
T haltHold2 0 0000 0000 0000 0026 0000 0 0002

/* verilog/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
    input  fetchPkg::opcodeT  opcode,
    output logic              regWrite,
    output fetchPkg::destSelT destSel,
    output logic              memEnable,
    output logic              memWr,
    output logic              val2Reg,
    output logic              aluSel,
    output fetchPkg::immSelT  immSel,
    output logic              bFlag,
    output logic              jFlag,
    output logic              regJmp,
    output logic              halt,
    output logic              ctrlErr
);

    import fetchPkg::*;

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        regWrite  = 1'b0;
        destSel   = DEST_RS;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        immSel    = IMM_NONE;
        bFlag     = 1'b0;
        jFlag     = 1'b0;
        regJmp    = 1'b0;
        halt      = 1'b0;
        ctrlErr   = 1'b0;

        case (opcode)
            OP_HALT: halt = 1'b1;
            OP_NOP: begin
            end
            OP_ADDI, OP_SUBI: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_I;
                aluSel   = 1'b1;     // Immediate as second operand
                immSel   = IMM_I5S;
            end
            OP_ST: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;
                immSel    = IMM_I5S;
            end
            OP_LD: begin
                regWrite  = 1'b1;
                destSel   = DEST_RD_I;
                memEnable = 1'b1;
                val2Reg   = 1'b1;    // Write back memory data
                aluSel    = 1'b1;
                immSel    = IMM_I5S;
            end
            OP_LBI: begin
                regWrite = 1'b1;
                destSel  = DEST_RS;
                aluSel   = 1'b1;
                immSel   = IMM_I8S;
            end
            OP_ALU: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_R;
            end
            OP_BEQZ, OP_BNEZ: begin
                bFlag  = 1'b1;
                immSel = IMM_I8S;
            end
            OP_J: begin
                jFlag  = 1'b1;
                immSel = IMM_D11S;
            end
            OP_JR: begin
                jFlag  = 1'b1;
                regJmp = 1'b1;
                immSel = IMM_I8S;
            end
            OP_JAL: begin
                jFlag    = 1'b1;
                regWrite = 1'b1;
                destSel  = DEST_R7;  // Return address
                immSel   = IMM_D11S;
            end
            OP_JALR: begin
                jFlag    = 1'b1;
                regJmp   = 1'b1;
                regWrite = 1'b1;
                destSel  = DEST_R7;
                immSel   = IMM_I8S;
            end
            default: ctrlErr = 1'b1;  // Unknown opcode
        endcase
    end

endmodule

`default_nettype wire

/* verilog/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              run,
    input  logic              pcSel,
    input  fetchPkg::addrT    brnchAddr,
    input  fetchPkg::dataT    rs,
    input  fetchPkg::dataT    imm,
    input  logic              loadReq,
    input  fetchPkg::addrT    loadAddr,
    input  fetchPkg::instrT   loadData,
    output logic              loadAck,
    output fetchPkg::addrT    pc,
    output fetchPkg::instrT   instrC,
    output fetchPkg::regAddrT writeRegAddr,
    output logic              regWrite,
    output logic              memEnable,
    output logic              memWr,
    output logic              val2Reg,
    output logic              aluSel,
    output fetchPkg::immSelT  immSel,
    output logic              bFlag,
    output logic              jFlag,
    output logic              regJmp,
    output logic              halt,
    output logic              ctrlErr
);

    import fetchPkg::*;

    instrT   rawInstr;
    logic    bubble;
    destSelT destSel;

    progCounter progCounter_i (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .pcSel     (pcSel),
        .brnchAddr (brnchAddr),
        .rs        (rs),
        .imm       (imm),
        .regJmp    (regJmp),
        .halt      (halt),
        .stall     (bubble),  // Load-use stall holds the PC
        .pc        (pc)
    );

    instrMem #(
        .MEM_WORDS (MEM_WORDS)
    ) instrMem_i (
        .clk      (clk),
        .arstN    (arstN),
        .addr     (pc),
        .loadReq  (loadReq),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .instr    (rawInstr),
        .loadAck  (loadAck)
    );

    hazardDetect hazardDetect_i (
        .clk    (clk),
        .arstN  (arstN),
        .run    (run),
        .instr  (rawInstr),
        .bubble (bubble)
    );

    // Idle or hazard both issue the NOP word
    assign instrC = (!run || bubble) ? NOP_INSTR : rawInstr;

    control control_i (
        .opcode    (instrC[15:11]),
        .regWrite  (regWrite),
        .destSel   (destSel),
        .memEnable (memEnable),
        .memWr     (memWr),
        .val2Reg   (val2Reg),
        .aluSel    (aluSel),
        .immSel    (immSel),
        .bFlag     (bFlag),
        .jFlag     (jFlag),
        .regJmp    (regJmp),
        .halt      (halt),
        .ctrlErr   (ctrlErr)
    );

    always_comb begin
        case (destSel)
            DEST_RS:   writeRegAddr = instrC[10:8];
            DEST_RD_R: writeRegAddr = instrC[4:2];
            DEST_R7:   writeRegAddr = regAddrT'(7);
            DEST_RD_I: writeRegAddr = instrC[7:5];
            default:   writeRegAddr = instrC[4:2];
        endcase
    end

    // Instructions are halfword aligned
    pcEvenA: assert property (
        @(posedge clk) disable iff (!arstN)
        pc[0] == 1'b0
    ) else $error("Odd PC %h", pc);

endmodule

`default_nettype wire

/* verilog/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    typedef logic [15:0] instrT;    // One instruction word
    typedef logic [15:0] addrT;     // Byte address, 2 bytes per instruction
    typedef logic [15:0] dataT;     // Register or immediate value
    typedef logic [2:0]  regAddrT;  // One of eight registers
    typedef logic [4:0]  opcodeT;   // Instr[15:11]
    typedef logic [1:0]  destSelT;
    typedef logic [2:0]  immSelT;

    // Bubble word, decodes as NOP
    localparam instrT NOP_INSTR = 16'h0800;

    localparam opcodeT OP_HALT = 5'b00000;
    localparam opcodeT OP_NOP  = 5'b00001;
    localparam opcodeT OP_J    = 5'b00100;
    localparam opcodeT OP_JR   = 5'b00101;
    localparam opcodeT OP_JAL  = 5'b00110;
    localparam opcodeT OP_JALR = 5'b00111;
    localparam opcodeT OP_ADDI = 5'b01000;
    localparam opcodeT OP_SUBI = 5'b01001;
    localparam opcodeT OP_BEQZ = 5'b01100;
    localparam opcodeT OP_BNEZ = 5'b01101;
    localparam opcodeT OP_ST   = 5'b10000;
    localparam opcodeT OP_LD   = 5'b10001;
    localparam opcodeT OP_LBI  = 5'b11000;
    localparam opcodeT OP_ALU  = 5'b11011;  // R-type arithmetic

    // Where the destination register number comes from
    localparam destSelT DEST_RS   = 2'b00;  // Instr[10:8]
    localparam destSelT DEST_RD_R = 2'b01;  // Instr[4:2]
    localparam destSelT DEST_R7   = 2'b10;  // Link register
    localparam destSelT DEST_RD_I = 2'b11;  // Instr[7:5]

    // Immediate formats seen by the extender downstream
    localparam immSelT IMM_NONE = 3'd0;
    localparam immSelT IMM_I5S  = 3'd1;  // 5 bit, sign extended
    localparam immSelT IMM_I8S  = 3'd2;  // 8 bit, sign extended
    localparam immSelT IMM_D11S = 3'd3;  // 11 bit jump displacement

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_WRITE,
        LOAD_ACK
    } loadStateT;

endpackage

`default_nettype wire

/* verilog/hazardDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardDetect (
    input  logic            clk,
    input  logic            arstN,
    input  logic            run,
    input  fetchPkg::instrT instr,
    output logic            bubble
);

    import fetchPkg::*;

    opcodeT  op;
    logic    readsRs;
    logic    readsRt;
    logic    ldValid;   // Previous accepted instruction was LD
    regAddrT ldDest;

    assign op = instr[15:11];

    // Which source fields the raw instruction reads
    always_comb begin
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (op)
            OP_ADDI, OP_SUBI, OP_LD, OP_BEQZ, OP_BNEZ, OP_JR, OP_JALR: begin
                readsRs = 1'b1;
            end
            OP_ST, OP_ALU: begin
                readsRs = 1'b1;
                readsRt = 1'b1;  // Rt, or store data
            end
            default: begin
            end
        endcase
    end

    assign bubble = run && ldValid &&
                    ((readsRs && (instr[10:8] == ldDest)) ||
                     (readsRt && (instr[7:5] == ldDest)));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ldValid <= 1'b0;
        end else if (!run || bubble) begin
            ldValid <= 1'b0;  // Held instruction passes next cycle
        end else begin
            ldValid <= (op == OP_LD);
        end
    end

    // LD destination is always Instr[7:5]
    always_ff @(posedge clk) begin
        if (run && !bubble) begin
            ldDest <= instr[7:5];
        end
    end

    oneBubbleA: assert property (
        @(posedge clk) disable iff (!arstN)
        bubble |=> !bubble
    ) else $error("Two bubbles in a row");

endmodule

`default_nettype wire

/* verilog/instrMem.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            arstN,
    input  fetchPkg::addrT  addr,
    input  logic            loadReq,
    input  fetchPkg::addrT  loadAddr,
    input  fetchPkg::instrT loadData,
    output fetchPkg::instrT instr,
    output logic            loadAck
);

    import fetchPkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    instrT mem [MEM_WORDS];

    loadStateT state;
    loadStateT stateNext;

    logic [IDX_W-1:0] rdIdx;
    logic [IDX_W-1:0] wrIdx;
    logic             wrEn;

    // Word index is byte address over two
    assign rdIdx = addr[IDX_W:1];
    assign wrIdx = loadAddr[IDX_W:1];

    assign instr = mem[rdIdx];  // Asynchronous read

    // Write lands on the edge that enters LOAD_WRITE
    assign wrEn = (state == LOAD_IDLE) && loadReq;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= loadData;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            LOAD_IDLE: begin
                if (loadReq) begin
                    stateNext = LOAD_WRITE;
                end
            end
            LOAD_WRITE: stateNext = LOAD_ACK;
            LOAD_ACK: begin
                // Wait for the loader to drop its request
                if (!loadReq) begin
                    stateNext = LOAD_IDLE;
                end
            end
            default: stateNext = LOAD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= LOAD_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    assign loadAck = (state == LOAD_ACK);

    // Loader must hold address and data for the whole request phase
    loadStableA: assert property (
        @(posedge clk) disable iff (!arstN)
        loadReq |=> (!loadReq || ($stable(loadAddr) && $stable(loadData)))
    ) else $error("loadAddr/loadData changed while loadReq high");

endmodule

`default_nettype wire

/* verilog/progCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module progCounter (
    input  logic           clk,
    input  logic           arstN,
    input  logic           run,
    input  logic           pcSel,
    input  fetchPkg::addrT brnchAddr,
    input  fetchPkg::dataT rs,
    input  fetchPkg::dataT imm,
    input  logic           regJmp,
    input  logic           halt,
    input  logic           stall,
    output fetchPkg::addrT pc
);

    import fetchPkg::*;

    addrT nextPc;
    addrT pcReg;

    // Priority: hold, then branch, then register jump, then sequential
    always_comb begin
        if (halt || stall) begin
            nextPc = pcReg;
        end else if (pcSel) begin
            nextPc = brnchAddr;
        end else if (regJmp) begin
            nextPc = rs + imm;  // JR / JALR target
        end else begin
            nextPc = pcReg + addrT'(2);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= '0;
        end else if (run) begin
            pcReg <= nextPc;
        end
    end

    assign pc = pcReg;

    // A hold request must freeze the PC across the following edge
    pcHoldA: assert property (
        @(posedge clk) disable iff (!arstN)
        (halt || stall || !run) |=> $stable(pcReg)
    ) else $error("PC moved during halt, stall or idle");

endmodule

`default_nettype wire
